// ==== project.f ====
rtl/timer_pkg.sv
rtl/timer_ctrl_if.sv
rtl/timer_regs.sv
rtl/timer_core.sv
rtl/timer_intr.sv
rtl/rv_timer.sv
testbench/tb_rv_timer.sv

// ==== rtl/rv_timer.sv ====
////////////////////////////////////////////////////////////
// RISC-V machine timer top level
// One hart, one comparator, Wishbone classic slave
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module rv_timer #(
  parameter int AW = timer_pkg::AW,
  parameter int DW = timer_pkg::DW
) (
  input  logic            clk_i,
  input  logic            arst_n_i,

  input  logic            wb_cyc_i,
  input  logic            wb_stb_i,
  input  logic            wb_we_i,
  input  logic [AW-1:0]   wb_adr_i,
  input  logic [DW-1:0]   wb_dat_i,
  // Byte selects are not supported, writes are full words
  input  logic [DW/8-1:0] wb_sel_i,
  output logic [DW-1:0]   wb_dat_o,
  output logic            wb_ack_o,

  output logic            intr_timer_expired_o
);

  logic intr_enable;
  logic intr_test;
  logic intr_clear;
  logic intr_cmp_wr;
  logic intr_state;

  timer_ctrl_if u_ctrl_if ();

  timer_regs #(
    .AW (AW),
    .DW (DW)
  ) u_regs (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .ctrl          (u_ctrl_if.regs),
    .intr_state_i  (intr_state),
    .intr_enable_o (intr_enable),
    .intr_test_o   (intr_test),
    .intr_clear_o  (intr_clear),
    .intr_cmp_wr_o (intr_cmp_wr)
  );

  timer_core u_core (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .ctrl     (u_ctrl_if.core)
  );

  // Expiry comes straight from the core compare
  timer_intr u_intr (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .event_i  (u_ctrl_if.expired),
    .enable_i (intr_enable),
    .test_i   (intr_test),
    .clear_i  (intr_clear),
    .cmp_wr_i (intr_cmp_wr),
    .state_o  (intr_state),
    .intr_o   (intr_timer_expired_o)
  );

endmodule

// ==== rtl/timer_core.sv ====
////////////////////////////////////////////////////////////
// Timer counter core
// Prescaler, tick generation, next mtime and compare
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module timer_core (
  input  logic       clk_i,
  input  logic       arst_n_i,

  timer_ctrl_if.core ctrl
);

  import timer_pkg::*;

  logic [PRESCALE_W-1:0] presc_cnt_q;
  logic                  presc_done;

  ////////////////////////////////////////////////////////////
  // Prescaler
  ////////////////////////////////////////////////////////////

  // Counts 0 .. prescaler, so a tick every prescaler+1 clocks
  assign presc_done = (presc_cnt_q >= ctrl.prescaler);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      presc_cnt_q <= '0;
    end else if (!ctrl.active) begin
      presc_cnt_q <= '0;
    end else if (presc_done) begin
      presc_cnt_q <= '0;
    end else begin
      presc_cnt_q <= presc_cnt_q + 1'b1;
    end
  end

  assign ctrl.tick = ctrl.active & presc_done;

  ////////////////////////////////////////////////////////////
  // Time update and compare
  ////////////////////////////////////////////////////////////

  // The CSR block loads this on a tick
  assign ctrl.mtime_next.count = ctrl.mtime.count + 64'(ctrl.step);

  // Level event, stays high until mtime or mtimecmp moves
  assign ctrl.expired = (ctrl.mtime.count >= ctrl.mtimecmp.count);

  // Stopping the timer must freeze mtime through the CSR block
  a_tick_active : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ctrl.tick |-> ctrl.active);

endmodule

// ==== rtl/timer_ctrl_if.sv ====
////////////////////////////////////////////////////////////
// Link between the CSR block and the counter core
// Carries configuration, time and compare values one way
// and tick, next time and expiry back
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

interface timer_ctrl_if;

  import timer_pkg::*;

  // Driven by the CSR block
  logic                  active;
  logic [PRESCALE_W-1:0] prescaler;
  logic [STEP_W-1:0]     step;
  time_u                 mtime;
  time_u                 mtimecmp;

  // Driven by the core
  logic                  tick;
  time_u                 mtime_next;
  logic                  expired;

  modport regs (
    output active, prescaler, step, mtime, mtimecmp,
    input  tick, mtime_next, expired
  );

  modport core (
    input  active, prescaler, step, mtime, mtimecmp,
    output tick, mtime_next, expired
  );

endinterface

// ==== rtl/timer_intr.sv ====
////////////////////////////////////////////////////////////
// Timer interrupt hardware
// State register with set/clear priority, registered output
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module timer_intr (
  input  logic clk_i,
  input  logic arst_n_i,

  input  logic event_i,
  input  logic enable_i,
  input  logic test_i,
  input  logic clear_i,
  input  logic cmp_wr_i,

  output logic state_o,
  output logic intr_o
);

  logic state_q;
  logic intr_q;
  logic state_set;
  logic state_clr;

  assign state_set = event_i | test_i;
  // A compare write drops a pending expiry
  assign state_clr = clear_i | cmp_wr_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= 1'b0;
      intr_q  <= 1'b0;
    end else begin
      // Clear wins over set
      if (state_clr) begin
        state_q <= 1'b0;
      end else if (state_set) begin
        state_q <= 1'b1;
      end
      intr_q <= state_q & enable_i;
    end
  end

  assign state_o = state_q;
  assign intr_o  = intr_q;

  a_intr_masked : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !enable_i |=> !intr_o);

endmodule

// ==== rtl/timer_pkg.sv ====
////////////////////////////////////////////////////////////
// Machine timer shared definitions
// Register offsets, CFG0 field layout, reset values
// and the 64-bit time word with its two views
////////////////////////////////////////////////////////////

package timer_pkg;

  // Wishbone widths, defaults for the top level parameters
  localparam int AW = 8;
  localparam int DW = 32;

  // Byte offsets of the CSRs
  typedef enum logic [7:0] {
    ADDR_CTRL        = 8'h00,
    ADDR_CFG0        = 8'h04,
    ADDR_TIMER_LOWER = 8'h08,
    ADDR_TIMER_UPPER = 8'h0C,
    ADDR_CMP_LOWER   = 8'h10,
    ADDR_CMP_UPPER   = 8'h14,
    ADDR_INTR_ENABLE = 8'h18,
    ADDR_INTR_STATE  = 8'h1C,
    ADDR_INTR_TEST   = 8'h20
  } addr_e;

  // CFG0 layout: prescaler in the low bits, step from bit 16
  localparam int PRESCALE_W   = 12;
  localparam int PRESCALE_LSB = 0;
  localparam int STEP_W       = 8;
  localparam int STEP_LSB     = 16;

  // Reset values
  localparam logic [63:0]           CMP_RESET      = '1;
  localparam logic [STEP_W-1:0]     STEP_RESET     = 8'd1;
  localparam logic [PRESCALE_W-1:0] PRESCALE_RESET = '0;

  // The bus side works on halves, the counter on the full word
  typedef struct packed {
    logic [31:0] upper;
    logic [31:0] lower;
  } time_half_t;

  typedef union packed {
    time_half_t  half;
    logic [63:0] count;
  } time_u;

endpackage

// ==== rtl/timer_regs.sv ====
////////////////////////////////////////////////////////////
// Wishbone classic slave with the timer CSRs
// Address decode, single-cycle ack, read mux and
// the interrupt hookup pulses
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module timer_regs #(
  parameter int AW = timer_pkg::AW,
  parameter int DW = timer_pkg::DW
) (
  input  logic          clk_i,
  input  logic          arst_n_i,

  input  logic          wb_cyc_i,
  input  logic          wb_stb_i,
  input  logic          wb_we_i,
  input  logic [AW-1:0] wb_adr_i,
  input  logic [DW-1:0] wb_dat_i,
  output logic [DW-1:0] wb_dat_o,
  output logic          wb_ack_o,

  timer_ctrl_if.regs    ctrl,

  input  logic          intr_state_i,
  output logic          intr_enable_o,
  output logic          intr_test_o,
  output logic          intr_clear_o,
  output logic          intr_cmp_wr_o
);

  import timer_pkg::*;

  logic                  ack_q;
  logic                  wr_en;
  logic [7:0]            reg_off;
  logic [DW-1:0]         reg_rdata;

  logic                  active_q;
  logic [PRESCALE_W-1:0] prescale_q;
  logic [STEP_W-1:0]     step_q;
  time_u                 mtime_q;
  time_u                 mtimecmp_q;
  logic                  intr_enable_q;

  ////////////////////////////////////////////////////////////
  // Bus handshake
  ////////////////////////////////////////////////////////////

  // Ack one clock after the request, then at least one idle cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wb_cyc_i & wb_stb_i & ~ack_q;
    end
  end

  assign wb_ack_o = ack_q;

  // Write lands on the edge that raises ack
  assign wr_en   = wb_cyc_i & wb_stb_i & wb_we_i & ~ack_q;
  assign reg_off = {wb_adr_i[7:2], 2'b00};

  ////////////////////////////////////////////////////////////
  // CSR storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q            <= 1'b0;
      prescale_q          <= PRESCALE_RESET;
      step_q              <= STEP_RESET;
      mtime_q.count       <= '0;
      mtimecmp_q.count    <= CMP_RESET;
      intr_enable_q       <= 1'b0;
    end else begin
      if (wr_en && reg_off == ADDR_CTRL) begin
        active_q <= wb_dat_i[0];
      end
      if (wr_en && reg_off == ADDR_CFG0) begin
        prescale_q <= wb_dat_i[PRESCALE_LSB +: PRESCALE_W];
        step_q     <= wb_dat_i[STEP_LSB +: STEP_W];
      end
      // A bus write to a time half wins over the tick update
      if (wr_en && reg_off == ADDR_TIMER_LOWER) begin
        mtime_q.half.lower <= wb_dat_i[31:0];
      end else if (ctrl.tick) begin
        mtime_q.half.lower <= ctrl.mtime_next.half.lower;
      end
      if (wr_en && reg_off == ADDR_TIMER_UPPER) begin
        mtime_q.half.upper <= wb_dat_i[31:0];
      end else if (ctrl.tick) begin
        mtime_q.half.upper <= ctrl.mtime_next.half.upper;
      end
      if (wr_en && reg_off == ADDR_CMP_LOWER) begin
        mtimecmp_q.half.lower <= wb_dat_i[31:0];
      end
      if (wr_en && reg_off == ADDR_CMP_UPPER) begin
        mtimecmp_q.half.upper <= wb_dat_i[31:0];
      end
      if (wr_en && reg_off == ADDR_INTR_ENABLE) begin
        intr_enable_q <= wb_dat_i[0];
      end
    end
  end

  assign ctrl.active    = active_q;
  assign ctrl.prescaler = prescale_q;
  assign ctrl.step      = step_q;
  assign ctrl.mtime     = mtime_q;
  assign ctrl.mtimecmp  = mtimecmp_q;

  // Interrupt block hookup
  assign intr_enable_o = intr_enable_q;
  assign intr_test_o   = wr_en & (reg_off == ADDR_INTR_TEST) & wb_dat_i[0];
  assign intr_clear_o  = wr_en & (reg_off == ADDR_INTR_STATE) & wb_dat_i[0];
  assign intr_cmp_wr_o = wr_en & ((reg_off == ADDR_CMP_LOWER) |
                                  (reg_off == ADDR_CMP_UPPER));

  ////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    reg_rdata = '0;
    case (reg_off)
      ADDR_CTRL:        reg_rdata[0] = active_q;
      ADDR_CFG0: begin
        reg_rdata[PRESCALE_LSB +: PRESCALE_W] = prescale_q;
        reg_rdata[STEP_LSB +: STEP_W]         = step_q;
      end
      ADDR_TIMER_LOWER: reg_rdata[31:0] = mtime_q.half.lower;
      ADDR_TIMER_UPPER: reg_rdata[31:0] = mtime_q.half.upper;
      ADDR_CMP_LOWER:   reg_rdata[31:0] = mtimecmp_q.half.lower;
      ADDR_CMP_UPPER:   reg_rdata[31:0] = mtimecmp_q.half.upper;
      ADDR_INTR_ENABLE: reg_rdata[0] = intr_enable_q;
      ADDR_INTR_STATE:  reg_rdata[0] = intr_state_i;
      // INTR_TEST is write-only
      default:          reg_rdata = '0;
    endcase
  end

  assign wb_dat_o = reg_rdata;

  // Back-to-back accesses still need an idle cycle between acks
  a_ack_single : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_ack_o |=> !wb_ack_o);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the machine timer testbench with Verilator
set -e

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_rv_timer \
  -f project.f \
  -Mdir obj_dir -o sim_tb_rv_timer

# The simulation status is judged from the log below
./obj_dir/sim_tb_rv_timer > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi

// ==== testbench/tb_rv_timer.sv ====
////////////////////////////////////////////////////////////
// Testbench for the machine timer
// Wishbone tasks, LCG, reference model, six tests,
// compare process and watchdog
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_rv_timer;

  // The six tests take a few hundred clocks in total
  localparam int WATCHDOG_CYCLES = 20000;

  localparam logic [7:0] A_CTRL   = 8'h00;
  localparam logic [7:0] A_CFG0   = 8'h04;
  localparam logic [7:0] A_TLOW   = 8'h08;
  localparam logic [7:0] A_TUP    = 8'h0C;
  localparam logic [7:0] A_CLOW   = 8'h10;
  localparam logic [7:0] A_CUP    = 8'h14;
  localparam logic [7:0] A_IEN    = 8'h18;
  localparam logic [7:0] A_ISTATE = 8'h1C;
  localparam logic [7:0] A_ITEST  = 8'h20;

  logic        clk_i;
  logic        arst_n_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [7:0]  wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [3:0]  wb_sel_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic        intr_timer_expired_o;

  // Shadow registers indexed by word offset
  logic [31:0] shadow [0:8];
  logic [31:0] seed = 32'h1f83;
  int unsigned clk_cnt = 0;
  int          cmp_errs = 0;
  int          misc_errs = 0;
  int          errs_before = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;
  string       chk_name_q [$];
  logic [31:0] chk_got_q [$];
  logic [31:0] chk_want_q [$];

  rv_timer u_rv_timer (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .wb_cyc_i             (wb_cyc_i),
    .wb_stb_i             (wb_stb_i),
    .wb_we_i              (wb_we_i),
    .wb_adr_i             (wb_adr_i),
    .wb_dat_i             (wb_dat_i),
    .wb_sel_i             (wb_sel_i),
    .wb_dat_o             (wb_dat_o),
    .wb_ack_o             (wb_ack_o),
    .intr_timer_expired_o (intr_timer_expired_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) clk_cnt <= clk_cnt + 1;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Time halves advance by n_steps times the shadow step
  function automatic logic [31:0] exp_reg(input logic [7:0] addr, input int unsigned n_steps);
    logic [63:0] t;
    t = {shadow[3], shadow[2]} + 64'(n_steps) * {56'd0, shadow[1][23:16]};
    case (addr)
      A_CTRL:   return shadow[0] & 32'h0000_0001;
      A_CFG0:   return shadow[1] & 32'h00ff_0fff;
      A_TLOW:   return t[31:0];
      A_TUP:    return t[63:32];
      A_CLOW:   return shadow[4];
      A_CUP:    return shadow[5];
      A_IEN:    return shadow[6] & 32'h0000_0001;
      A_ISTATE: return shadow[7] & 32'h0000_0001;
      default:  return 32'h0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Bus and check tasks
  ////////////////////////////////////////////////////////////

  // Holds the request until ack, sampled 5 ns after each edge
  task automatic bus_cycle();
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      #5;
      n++;
    end while (!wb_ack_o && n < 16);
    if (!wb_ack_o) begin
      $display("No ack from the bus slave for address %h", wb_adr_i);
      misc_errs++;
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [7:0] addr, input logic [31:0] data);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = addr;
    wb_dat_i = data;
    bus_cycle();
  endtask

  task automatic wb_read(input logic [7:0] addr, output logic [31:0] data);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = addr;
    bus_cycle();
    data = wb_dat_o;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    wb_write(addr, data);
    shadow[int'(addr[7:2])] = data;
  endtask

  task automatic queue_check(input string name, input logic [31:0] got, input logic [31:0] want);
    chk_name_q.push_back(name);
    chk_got_q.push_back(got);
    chk_want_q.push_back(want);
  endtask

  task automatic check_reg(input logic [7:0] addr);
    logic [31:0] got;
    wb_read(addr, got);
    queue_check($sformatf("reg_%02h", addr), got, exp_reg(addr, 0));
  endtask

  task automatic wait_intr(input logic level, input int limit);
    int n;
    n = 0;
    while (intr_timer_expired_o !== level && n < limit) begin
      @(posedge clk_i);
      #5;
      n++;
    end
    if (intr_timer_expired_o !== level) begin
      $display("Interrupt output did not reach %b within %0d cycles", level, limit);
      misc_errs++;
    end
  endtask

  task automatic end_test(input string name);
    @(posedge clk_i);
    #5;
    if (cmp_errs + misc_errs == errs_before) begin
      $display("%s: ok", name);
      tests_ok++;
    end else begin
      $display("%s: failed", name);
      tests_bad++;
    end
    errs_before = cmp_errs + misc_errs;
  endtask

  always @(posedge clk_i) begin : compare_proc
    string       nm;
    logic [31:0] got;
    logic [31:0] want;
    while (chk_got_q.size() > 0) begin
      nm   = chk_name_q.pop_front();
      got  = chk_got_q.pop_front();
      want = chk_want_q.pop_front();
      if (got !== want) begin
        $display("** Error at %0t: %s = %h, expected %h", $time, nm, got, want);
        cmp_errs++;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  initial begin : main
    logic [31:0] rd;
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] u;
    logic [7:0]  rw_addr [0:5];
    int unsigned t_a;
    int unsigned t_b;
    int unsigned p;
    int unsigned s;
    int unsigned steps;
    int unsigned ticks;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = 8'h00;
    wb_dat_i = 32'h0;
    wb_sel_i = 4'hf;
    arst_n_i = 1'b0;
    rw_addr  = '{A_CFG0, A_TLOW, A_TUP, A_CLOW, A_CUP, A_IEN};
    // Reset values with step 1 and prescaler 0 in CFG0
    shadow   = '{32'h0, 32'h0001_0000, 32'h0, 32'h0, '1, '1, 32'h0, 32'h0, 32'h0};
    repeat (10) @(posedge clk_i);
    #5;
    arst_n_i = 1'b1;

    for (int i = 0; i < 9; i++) check_reg(8'(4 * i));
    queue_check("intr_timer_expired_o", {31'd0, intr_timer_expired_o}, 32'd0);
    end_test("Test 1 reset values");

    write_reg(A_CTRL, 32'd0);
    for (int i = 0; i < 20; i++) begin
      seed = lcg_next(seed);
      write_reg(rw_addr[i % 6], seed);
      check_reg(rw_addr[i % 6]);
    end
    check_reg(A_ITEST);
    end_test("Test 2 read-back");

    seed = lcg_next(seed);
    p = seed % 4;
    s = (seed >> 8) % 15 + 1;
    write_reg(A_CFG0, (s << 16) | p);
    write_reg(A_TLOW, 32'd0);
    write_reg(A_TUP, 32'd0);
    write_reg(A_CTRL, 32'd1);
    t_a = clk_cnt;
    repeat (8) begin
      wb_read(A_CTRL, rd);
      queue_check("ctrl", rd, exp_reg(A_CTRL, 0));
    end
    write_reg(A_CTRL, 32'd0);
    t_b = clk_cnt;
    wb_read(A_TLOW, lo);
    wb_read(A_TUP, hi);
    steps = lo / s;
    ticks = (t_b - t_a) / (p + 1);
    queue_check("timer_lower mod step", lo % s, 32'd0);
    queue_check("timer_upper", hi, exp_reg(A_TUP, ticks));
    if (steps + 1 < ticks || steps > ticks + 1) begin
      $display("Step count %0d is not within one of %0d ticks", steps, ticks);
      misc_errs++;
    end
    end_test("Test 3 counting");

    seed = lcg_next(seed);
    u = seed;
    write_reg(A_TLOW, 32'hffff_fff0);
    write_reg(A_TUP, u);
    write_reg(A_CFG0, 32'h0020_0000);
    write_reg(A_CTRL, 32'd1);
    t_a = clk_cnt;
    wb_read(A_CTRL, rd);
    queue_check("ctrl", rd, exp_reg(A_CTRL, 0));
    write_reg(A_CTRL, 32'd0);
    t_b = clk_cnt;
    wb_read(A_TLOW, lo);
    wb_read(A_TUP, hi);
    // Prescaler 0 gives one step per clock while active
    queue_check("timer_lower", lo, exp_reg(A_TLOW, t_b - t_a));
    queue_check("timer_upper", hi, exp_reg(A_TUP, t_b - t_a));
    queue_check("timer_upper carry", hi, u + 32'd1);
    end_test("Test 4 64-bit carry");

    write_reg(A_TUP, 32'd0);
    write_reg(A_TLOW, 32'h100);
    write_reg(A_CUP, '1);
    write_reg(A_CLOW, 32'h140);
    write_reg(A_CFG0, 32'h0001_0000);
    write_reg(A_IEN, 32'd1);
    write_reg(A_CUP, 32'd0);
    wait_intr(1'b0, 4);
    write_reg(A_CTRL, 32'd1);
    wait_intr(1'b1, 200);
    wb_read(A_ISTATE, rd);
    queue_check("intr_state", rd, 32'd1);
    wb_read(A_TUP, hi);
    wb_read(A_TLOW, lo);
    if (hi != 32'd0 || lo < 32'h140) begin
      $display("** Error at %0t: timer = %h_%h, expected at least 0_00000140", $time, hi, lo);
      misc_errs++;
    end
    write_reg(A_CUP, 32'h0000_1000);
    wb_read(A_ISTATE, rd);
    queue_check("intr_state", rd, 32'd0);
    wait_intr(1'b0, 4);
    write_reg(A_CTRL, 32'd0);
    end_test("Test 5 compare expiry");

    write_reg(A_CLOW, '1);
    write_reg(A_CUP, '1);
    wb_write(A_ITEST, 32'd1);
    wait_intr(1'b1, 4);
    write_reg(A_IEN, 32'd0);
    wait_intr(1'b0, 4);
    wb_read(A_ISTATE, rd);
    queue_check("intr_state", rd, 32'd1);
    wb_write(A_ISTATE, 32'd1);
    wb_read(A_ISTATE, rd);
    queue_check("intr_state", rd, 32'd0);
    end_test("Test 6 test register and masking");

    $display("Tests passed: %0d, failed: %0d", tests_ok, tests_bad);
    if (tests_bad == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
